// ==== vlog.f ====
+incdir+hw
hw/lmem_csr_pkg.sv
hw/lmem_avmm_pkg.sv
hw/lmem_apb_regs.sv
hw/mem_chan.sv
hw/local_mem.sv
hw/local_mem_top.sv
tests/tb_clk_gen.sv
tests/avmm_mem_model.sv
tests/tb_local_mem.sv

// ==== tests/tb_local_mem.sv ====
`include "lmem_defs.svh"

module tb_local_mem;

  localparam int n_trans = 300;
  localparam int cycle_limit = n_trans * 40 + 2000;
  localparam logic [26:0] addr_base = 27'h0123450; // 16-line window

  logic         Clk_400;
  logic         arst_n;
  logic [7:0]   paddr;
  logic         psel;
  logic         penable;
  logic         pwrite;
  logic [63:0]  pwdata;
  logic [63:0]  prdata;
  logic         pready;
  logic         pslverr;
  logic         stall_a;
  logic         stall_b;
  logic         ddr4a_read;
  logic         ddr4a_write;
  logic [26:0]  ddr4a_address;
  logic [511:0] ddr4a_writedata;
  logic [63:0]  ddr4a_byteenable;
  logic         ddr4a_waitrequest;
  logic [511:0] ddr4a_readdata;
  logic         ddr4a_readdatavalid;
  logic         ddr4b_read;
  logic         ddr4b_write;
  logic [26:0]  ddr4b_address;
  logic [511:0] ddr4b_writedata;
  logic [63:0]  ddr4b_byteenable;
  logic         ddr4b_waitrequest;
  logic [511:0] ddr4b_readdata;
  logic         ddr4b_readdatavalid;

  logic [511:0] shadow [0:1][0:15];
  logic [26:0]  exp_addr [0:1];
  logic [63:0]  exp_wdata [0:1];
  logic [7:0]   exp_be [0:1];
  int           exp_wr [0:1];
  int           exp_rd [0:1];
  int           seen_wr [0:1];
  int           seen_rd [0:1];
  int           checks = 0;
  int           errors = 0;
  int           cycles = 0;

  tb_clk_gen u_clk_gen (
    .Clk_400 (Clk_400),
    .arst_n  (arst_n)
  );

  local_mem_top u_local_mem_top (
    .Clk_400             (Clk_400),
    .arst_n              (arst_n),
    .paddr               (paddr),
    .psel                (psel),
    .penable             (penable),
    .pwrite              (pwrite),
    .pwdata              (pwdata),
    .prdata              (prdata),
    .pready              (pready),
    .pslverr             (pslverr),
    .ddr4a_read          (ddr4a_read),
    .ddr4a_write         (ddr4a_write),
    .ddr4a_address       (ddr4a_address),
    .ddr4a_writedata     (ddr4a_writedata),
    .ddr4a_byteenable    (ddr4a_byteenable),
    .ddr4a_waitrequest   (ddr4a_waitrequest),
    .ddr4a_readdata      (ddr4a_readdata),
    .ddr4a_readdatavalid (ddr4a_readdatavalid),
    .ddr4b_read          (ddr4b_read),
    .ddr4b_write         (ddr4b_write),
    .ddr4b_address       (ddr4b_address),
    .ddr4b_writedata     (ddr4b_writedata),
    .ddr4b_byteenable    (ddr4b_byteenable),
    .ddr4b_waitrequest   (ddr4b_waitrequest),
    .ddr4b_readdata      (ddr4b_readdata),
    .ddr4b_readdatavalid (ddr4b_readdatavalid)
  );

  avmm_mem_model u_mem_a (
    .Clk_400       (Clk_400),
    .arst_n        (arst_n),
    .stall         (stall_a),
    .read          (ddr4a_read),
    .write         (ddr4a_write),
    .address       (ddr4a_address),
    .writedata     (ddr4a_writedata),
    .byteenable    (ddr4a_byteenable),
    .waitrequest   (ddr4a_waitrequest),
    .readdata      (ddr4a_readdata),
    .readdatavalid (ddr4a_readdatavalid)
  );

  avmm_mem_model u_mem_b (
    .Clk_400       (Clk_400),
    .arst_n        (arst_n),
    .stall         (stall_b),
    .read          (ddr4b_read),
    .write         (ddr4b_write),
    .address       (ddr4b_address),
    .writedata     (ddr4b_writedata),
    .byteenable    (ddr4b_byteenable),
    .waitrequest   (ddr4b_waitrequest),
    .readdata      (ddr4b_readdata),
    .readdatavalid (ddr4b_readdatavalid)
  );

  task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // pattern covers channel, full address and lane
  function automatic logic [511:0] fill_line(input int ch, input logic [26:0] addr);
    logic [511:0] line;
    for (int j = 0; j < 8; j++) begin
      line[j*64 +: 64] = {ch[0], 4'h0, addr, 8'(j), 24'h9e37b5};
    end
    return line;
  endfunction

  // setup, access, sample mid access, release
  task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [63:0] data,
                          output logic [63:0] rdata, output logic err);
    @(posedge Clk_400);
    psel    <= 1'b1;
    penable <= 1'b0;
    paddr   <= addr;
    pwrite  <= wr;
    pwdata  <= data;
    @(posedge Clk_400);
    penable <= 1'b1;
    @(negedge Clk_400);
    rdata = prdata;
    err   = pslverr;
    expect_eq("apb pready", 64'd1, {63'd0, pready});
    @(posedge Clk_400);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [63:0] data);
    logic [63:0] unused;
    logic        err;
    apb_xfer(addr, 1'b1, data, unused, err);
    expect_eq("register write pslverr", 64'd0, {63'd0, err});
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [63:0] data);
    logic err;
    apb_xfer(addr, 1'b0, 64'd0, data, err);
    expect_eq("register read pslverr", 64'd0, {63'd0, err});
  endtask

  // busy is bit 3 for a, bit 6 for b
  task automatic wait_idle(input int ch, output logic [63:0] st);
    do begin
      reg_read(`LMEM_REG_STATUS, st);
    end while (st[ch == 0 ? 3 : 6]);
  endtask

  task automatic watch_chan(input int ch, input logic rd, input logic wr, input logic stalled,
                            input logic [26:0] addr, input logic [511:0] wdata,
                            input logic [63:0] be);
    if (wr && !stalled) begin
      seen_wr[ch]++;
      expect_eq("write address", {37'd0, exp_addr[ch]}, {37'd0, addr});
      for (int j = 0; j < 8; j++) begin
        expect_eq("write lane", exp_wdata[ch], wdata[j*64 +: 64]);
      end
      expect_eq("write byteenable", {8{exp_be[ch]}}, be);
    end
    if (rd && !stalled) begin
      seen_rd[ch]++;
      expect_eq("read address", {37'd0, exp_addr[ch]}, {37'd0, addr});
    end
  endtask

  always @(posedge Clk_400) begin
    watch_chan(0, ddr4a_read, ddr4a_write, ddr4a_waitrequest, ddr4a_address,
               ddr4a_writedata, ddr4a_byteenable);
    watch_chan(1, ddr4b_read, ddr4b_write, ddr4b_waitrequest, ddr4b_address,
               ddr4b_writedata, ddr4b_byteenable);
  end

  always @(posedge Clk_400) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("checks %0d, errors %0d", checks, errors);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic shadow_write(input int ch, input int idx, input logic [63:0] data,
                              input logic [7:0] be);
    for (int j = 0; j < 8; j++) begin
      for (int k = 0; k < 8; k++) begin
        if (be[k])
          shadow[ch][idx][j*64 + k*8 +: 8] = data[k*8 +: 8];
      end
    end
  endtask

  // one command, optionally followed by a second one that must be refused
  task automatic run_cmd(input int ch, input logic is_wr, input int idx, input logic [63:0] data,
                         input logic [7:0] be, input logic [2:0] sel, input logic refuse);
    logic [63:0]  st;
    logic [63:0]  rdata;
    logic [63:0]  ctrl;
    logic [63:0]  bad_ctrl;
    logic [511:0] line;
    logic         err;
    ctrl = '0;
    ctrl[ch*2 + (is_wr ? 0 : 1)] = 1'b1;
    ctrl[11:4]  = be;
    ctrl[18:16] = sel;
    bad_ctrl = '0;
    bad_ctrl[ch*2 + (is_wr ? 1 : 0)] = 1'b1; // opposite op, same channel
    exp_addr[ch]  = addr_base + 27'(idx);
    exp_wdata[ch] = data;
    exp_be[ch]    = be;
    if (is_wr)
      exp_wr[ch]++;
    else
      exp_rd[ch]++;
    reg_write(`LMEM_REG_ADDR, {37'd0, exp_addr[ch]});
    if (is_wr)
      reg_write(`LMEM_REG_WDATA, data);
    reg_write(`LMEM_REG_CTRL, ctrl);
    if (refuse) begin
      apb_xfer(`LMEM_REG_CTRL, 1'b1, bad_ctrl, rdata, err);
      expect_eq("busy refusal pslverr", 64'd1, {63'd0, err});
    end
    if (!is_wr) begin
      reg_read(`LMEM_REG_STATUS, st);
      expect_eq("data_valid after read start", 64'd0, {63'd0, st[0]});
    end
    wait_idle(ch, st);
    expect_eq("timeout flags", 64'd0, {60'd0, st[5:4], st[2:1]});
    if (is_wr) begin
      shadow_write(ch, idx, data, be);
      line = (ch == 0) ? u_mem_a.mem[idx] : u_mem_b.mem[idx];
      for (int j = 0; j < 8; j++) begin
        expect_eq("memory lane", shadow[ch][idx][j*64 +: 64], line[j*64 +: 64]);
      end
    end else begin
      reg_read(`LMEM_REG_STATUS, st);
      expect_eq("data_valid after read done", 64'd1, {63'd0, st[0]});
      reg_read(`LMEM_REG_RDATA, rdata);
      expect_eq("read data", shadow[ch][idx][sel*64 +: 64], rdata);
    end
    expect_eq("avalon write count", exp_wr[ch], seen_wr[ch]);
    expect_eq("avalon read count", exp_rd[ch], seen_rd[ch]);
  endtask

  initial begin
    logic [63:0] st;
    int          ch;
    logic        is_wr;
    int          idx;
    logic [63:0] data;
    logic [7:0]  be;
    logic [2:0]  sel;
    logic        refuse;
    int          t_start;
    void'($urandom(32'h6d4f5cd0));
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    stall_a = 1'b0;
    stall_b = 1'b0;
    for (int c = 0; c < 2; c++) begin
      exp_addr[c]  = '0;
      exp_wdata[c] = '0;
      exp_be[c]    = '0;
      exp_wr[c]    = 0;
      exp_rd[c]    = 0;
      seen_wr[c]   = 0;
      seen_rd[c]   = 0;
      for (int i = 0; i < 16; i++) begin
        shadow[c][i] = fill_line(c, addr_base + 27'(i));
      end
    end
    for (int i = 0; i < 16; i++) begin
      u_mem_a.mem[i] = shadow[0][i]; // preload both models
      u_mem_b.mem[i] = shadow[1][i];
    end

    @(posedge arst_n);
    repeat (2) @(posedge Clk_400);
    @(negedge Clk_400);
    expect_eq("avalon idle after reset", 64'd0,
              {60'd0, ddr4a_read, ddr4a_write, ddr4b_read, ddr4b_write});
    reg_read(`LMEM_REG_STATUS, st);
    expect_eq("status after reset", 64'd0, st);
    expect_eq("avalon accesses before commands", 64'd0,
              seen_wr[0] + seen_wr[1] + seen_rd[0] + seen_rd[1]);

    for (int t = 0; t < n_trans; t++) begin
      ch     = $urandom_range(0, 1);
      is_wr  = $urandom_range(0, 1);
      idx    = $urandom_range(0, 15);
      data   = {$urandom, $urandom};
      be     = $urandom_range(0, 255);
      sel    = $urandom_range(0, 7);
      refuse = ($urandom_range(0, 7) == 0);
      run_cmd(ch, is_wr, idx, data, be, sel, refuse);
    end

    // stalled channel b, read gives up
    @(posedge Clk_400);
    stall_b <= 1'b1;
    reg_write(`LMEM_REG_ADDR, {37'd0, addr_base + 27'd3});
    reg_write(`LMEM_REG_CTRL, 64'h8);
    t_start = cycles;
    wait_idle(1, st);
    checks++;
    assert (cycles - t_start >= `LMEM_TIMEOUT) else begin
      errors++;
      $display("error b timeout delay: expected at least %0d cycles, actual %0d",
               `LMEM_TIMEOUT, cycles - t_start);
    end
    reg_read(`LMEM_REG_STATUS, st);
    expect_eq("b read timeout", 64'd1, {63'd0, st[5]});
    expect_eq("b busy after timeout", 64'd0, {63'd0, st[6]});
    expect_eq("data_valid after timeout", 64'd0, {63'd0, st[0]});
    expect_eq("avalon read count after timeout", exp_rd[1], seen_rd[1]);
    @(posedge Clk_400);
    stall_b <= 1'b0;
    run_cmd(1, 1'b1, 5, {$urandom, $urandom}, 8'hff, 3'd0, 1'b0); // clears the flag

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== tests/avmm_mem_model.sv ====
module avmm_mem_model (
  input  logic         Clk_400,
  input  logic         arst_n,
  input  logic         stall,
  input  logic         read,
  input  logic         write,
  input  logic [26:0]  address,
  input  logic [511:0] writedata,
  input  logic [63:0]  byteenable,
  output logic         waitrequest,
  output logic [511:0] readdata,
  output logic         readdatavalid
);

  // 16 lines, indexed by the low address bits
  logic [511:0] mem [0:15];
  logic [2:0]   wait_left;
  logic [2:0]   lat_left;
  logic         pending;
  logic [511:0] rd_line;
  logic         accept;

  assign waitrequest = stall | (wait_left != 3'd0);
  assign accept      = (read | write) & ~waitrequest;

  always @(posedge Clk_400 or negedge arst_n) begin
    if (!arst_n) begin
      wait_left     <= 3'd0;
      lat_left      <= 3'd0;
      pending       <= 1'b0;
      rd_line       <= '0;
      readdata      <= '0;
      readdatavalid <= 1'b0;
    end else begin
      readdatavalid <= 1'b0;
      if ((read || write) && !stall) begin
        if (wait_left != 3'd0)
          wait_left <= wait_left - 3'd1;
        else
          wait_left <= 3'($urandom_range(0, 5)); // stretch for the next command
      end
      if (accept && write) begin
        for (int i = 0; i < 64; i++) begin
          if (byteenable[i])
            mem[address[3:0]][i*8 +: 8] <= writedata[i*8 +: 8];
        end
      end
      if (accept && read) begin
        pending  <= 1'b1;
        lat_left <= 3'($urandom_range(1, 6));
        rd_line  <= mem[address[3:0]];
      end
      // one beat per read
      if (pending) begin
        if (lat_left == 3'd1) begin
          readdatavalid <= 1'b1;
          readdata      <= rd_line;
          pending       <= 1'b0;
        end else begin
          lat_left <= lat_left - 3'd1;
        end
      end
    end
  end

endmodule

// ==== tests/tb_clk_gen.sv ====
module tb_clk_gen (
  output logic Clk_400,
  output logic arst_n
);

  initial begin
    Clk_400 = 1'b0;
    forever #2 Clk_400 = ~Clk_400; // period 4
  end

  // low for three clock periods, released on a falling edge
  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge Clk_400);
    @(negedge Clk_400);
    arst_n = 1'b1;
  end

endmodule

// ==== hw/local_mem_top.sv ====
`include "lmem_defs.svh"

module local_mem_top import lmem_csr_pkg::*; (
  input  logic                                Clk_400,
  input  logic                                arst_n,
  input  logic [7:0]                          paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [`LMEM_DATA_W-1:0]             pwdata,
  output logic [`LMEM_DATA_W-1:0]             prdata,
  output logic                                pready,
  output logic                                pslverr,
  output logic                                ddr4a_read,
  output logic                                ddr4a_write,
  output logic [`LMEM_ADDR_W-1:0]             ddr4a_address,
  output logic [`LMEM_LANES*`LMEM_DATA_W-1:0] ddr4a_writedata,
  output logic [`LMEM_LANES*`LMEM_BE_W-1:0]   ddr4a_byteenable,
  input  logic                                ddr4a_waitrequest,
  input  logic [`LMEM_LANES*`LMEM_DATA_W-1:0] ddr4a_readdata,
  input  logic                                ddr4a_readdatavalid,
  output logic                                ddr4b_read,
  output logic                                ddr4b_write,
  output logic [`LMEM_ADDR_W-1:0]             ddr4b_address,
  output logic [`LMEM_LANES*`LMEM_DATA_W-1:0] ddr4b_writedata,
  output logic [`LMEM_LANES*`LMEM_BE_W-1:0]   ddr4b_byteenable,
  input  logic                                ddr4b_waitrequest,
  input  logic [`LMEM_LANES*`LMEM_DATA_W-1:0] ddr4b_readdata,
  input  logic                                ddr4b_readdatavalid
);

  logic                    cmd_valid;
  lmem_ctrl_t              cmd_ctrl;
  logic [`LMEM_ADDR_W-1:0] cmd_address;
  logic [`LMEM_DATA_W-1:0] cmd_wdata;
  logic [`LMEM_DATA_W-1:0] host_rdata;
  lmem_status_t            host_status;

  lmem_apb_regs u_regs (
    .Clk_400     (Clk_400),
    .arst_n      (arst_n),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .cmd_valid   (cmd_valid),
    .cmd_ctrl    (cmd_ctrl),
    .cmd_address (cmd_address),
    .cmd_wdata   (cmd_wdata),
    .host_rdata  (host_rdata),
    .host_status (host_status)
  );

  local_mem u_local_mem (
    .Clk_400             (Clk_400),
    .arst_n              (arst_n),
    .cmd_valid           (cmd_valid),
    .cmd_ctrl            (cmd_ctrl),
    .cmd_address         (cmd_address),
    .cmd_wdata           (cmd_wdata),
    .host_rdata          (host_rdata),
    .host_status         (host_status),
    .ddr4a_read          (ddr4a_read),
    .ddr4a_write         (ddr4a_write),
    .ddr4a_address       (ddr4a_address),
    .ddr4a_writedata     (ddr4a_writedata),
    .ddr4a_byteenable    (ddr4a_byteenable),
    .ddr4a_waitrequest   (ddr4a_waitrequest),
    .ddr4a_readdata      (ddr4a_readdata),
    .ddr4a_readdatavalid (ddr4a_readdatavalid),
    .ddr4b_read          (ddr4b_read),
    .ddr4b_write         (ddr4b_write),
    .ddr4b_address       (ddr4b_address),
    .ddr4b_writedata     (ddr4b_writedata),
    .ddr4b_byteenable    (ddr4b_byteenable),
    .ddr4b_waitrequest   (ddr4b_waitrequest),
    .ddr4b_readdata      (ddr4b_readdata),
    .ddr4b_readdatavalid (ddr4b_readdatavalid)
  );

endmodule

// ==== hw/local_mem.sv ====
`include "lmem_defs.svh"

module local_mem import lmem_csr_pkg::*, lmem_avmm_pkg::*; (
  input  logic                                Clk_400,
  input  logic                                arst_n,
  input  logic                                cmd_valid,
  input  lmem_ctrl_t                          cmd_ctrl,
  input  logic [`LMEM_ADDR_W-1:0]             cmd_address,
  input  logic [`LMEM_DATA_W-1:0]             cmd_wdata,
  output logic [`LMEM_DATA_W-1:0]             host_rdata,
  output lmem_status_t                        host_status,
  output logic                                ddr4a_read,
  output logic                                ddr4a_write,
  output logic [`LMEM_ADDR_W-1:0]             ddr4a_address,
  output logic [`LMEM_LANES*`LMEM_DATA_W-1:0] ddr4a_writedata,
  output logic [`LMEM_LANES*`LMEM_BE_W-1:0]   ddr4a_byteenable,
  input  logic                                ddr4a_waitrequest,
  input  logic [`LMEM_LANES*`LMEM_DATA_W-1:0] ddr4a_readdata,
  input  logic                                ddr4a_readdatavalid,
  output logic                                ddr4b_read,
  output logic                                ddr4b_write,
  output logic [`LMEM_ADDR_W-1:0]             ddr4b_address,
  output logic [`LMEM_LANES*`LMEM_DATA_W-1:0] ddr4b_writedata,
  output logic [`LMEM_LANES*`LMEM_BE_W-1:0]   ddr4b_byteenable,
  input  logic                                ddr4b_waitrequest,
  input  logic [`LMEM_LANES*`LMEM_DATA_W-1:0] ddr4b_readdata,
  input  logic                                ddr4b_readdatavalid
);

  lmem_ctrl_t              ctrl_q;
  logic [`LMEM_ADDR_W-1:0] addr_q;
  logic [`LMEM_DATA_W-1:0] wdata_q;
  logic                    start_a_wr;
  logic                    start_a_rd;
  logic                    start_b_wr;
  logic                    start_b_rd;
  lmem_chan_e              rd_sel;
  logic                    data_valid;
  logic                    a_busy;
  logic                    b_busy;
  logic                    a_rd_done;
  logic                    b_rd_done;
  logic [`LMEM_DATA_W-1:0] a_rdata;
  logic [`LMEM_DATA_W-1:0] b_rdata;
  logic                    a_wr_tmo;
  logic                    a_rd_tmo;
  logic                    b_wr_tmo;
  logic                    b_rd_tmo;
  lmem_line_t              a_wline;
  lmem_line_t              a_rline;
  lmem_line_t              b_wline;
  lmem_line_t              b_rline;

  // command stage, payload only moves on cmd_valid
  always_ff @(posedge Clk_400) begin
    if (cmd_valid) begin
      ctrl_q  <= cmd_ctrl;
      addr_q  <= cmd_address;
      wdata_q <= cmd_wdata;
    end
  end

  always_ff @(posedge Clk_400 or negedge arst_n) begin
    if (!arst_n) begin
      start_a_wr <= 1'b0;
      start_a_rd <= 1'b0;
      start_b_wr <= 1'b0;
      start_b_rd <= 1'b0;
      rd_sel     <= chan_a;
      data_valid <= 1'b0;
    end else begin
      start_a_wr <= cmd_valid & cmd_ctrl.a_write;
      start_a_rd <= cmd_valid & cmd_ctrl.a_read;
      start_b_wr <= cmd_valid & cmd_ctrl.b_write;
      start_b_rd <= cmd_valid & cmd_ctrl.b_read;
      if (start_a_rd || start_b_rd)
        rd_sel <= start_b_rd ? chan_b : chan_a;
      // new read clears, done from the owning channel sets
      if (start_a_rd || start_b_rd)
        data_valid <= 1'b0;
      else if (rd_sel == chan_b ? b_rd_done : a_rd_done)
        data_valid <= 1'b1;
    end
  end

  assign host_rdata = (rd_sel == chan_b) ? b_rdata : a_rdata;

  always_comb begin
    host_status                 = '0;
    host_status.data_valid      = data_valid;
    host_status.a_write_timeout = a_wr_tmo;
    host_status.a_read_timeout  = a_rd_tmo;
    host_status.a_busy          = a_busy;
    host_status.b_write_timeout = b_wr_tmo;
    host_status.b_read_timeout  = b_rd_tmo;
    host_status.b_busy          = b_busy;
  end

  // flat bus toward avalon
  assign ddr4a_writedata = a_wline.flat;
  assign ddr4b_writedata = b_wline.flat;
  assign a_rline.flat    = ddr4a_readdata;
  assign b_rline.flat    = ddr4b_readdata;

  mem_chan u_chan_a (
    .Clk_400           (Clk_400),
    .arst_n            (arst_n),
    .start_write       (start_a_wr),
    .start_read        (start_a_rd),
    .address           (addr_q),
    .wdata             (wdata_q),
    .byteenable        (ctrl_q.byteenable),
    .word_sel          (ctrl_q.word_sel),
    .busy              (a_busy),
    .rd_done           (a_rd_done),
    .rdata             (a_rdata),
    .write_timeout     (a_wr_tmo),
    .read_timeout      (a_rd_tmo),
    .avm_read          (ddr4a_read),
    .avm_write         (ddr4a_write),
    .avm_address       (ddr4a_address),
    .avm_writedata     (a_wline),
    .avm_byteenable    (ddr4a_byteenable),
    .avm_waitrequest   (ddr4a_waitrequest),
    .avm_readdata      (a_rline),
    .avm_readdatavalid (ddr4a_readdatavalid)
  );

  mem_chan u_chan_b (
    .Clk_400           (Clk_400),
    .arst_n            (arst_n),
    .start_write       (start_b_wr),
    .start_read        (start_b_rd),
    .address           (addr_q),
    .wdata             (wdata_q),
    .byteenable        (ctrl_q.byteenable),
    .word_sel          (ctrl_q.word_sel),
    .busy              (b_busy),
    .rd_done           (b_rd_done),
    .rdata             (b_rdata),
    .write_timeout     (b_wr_tmo),
    .read_timeout      (b_rd_tmo),
    .avm_read          (ddr4b_read),
    .avm_write         (ddr4b_write),
    .avm_address       (ddr4b_address),
    .avm_writedata     (b_wline),
    .avm_byteenable    (ddr4b_byteenable),
    .avm_waitrequest   (ddr4b_waitrequest),
    .avm_readdata      (b_rline),
    .avm_readdatavalid (ddr4b_readdatavalid)
  );

  // the apb busy check keeps a new read off a channel still finishing one
  a_no_done_on_start: assert property (
    @(posedge Clk_400) disable iff (!arst_n)
    !(a_rd_done && start_a_rd) && !(b_rd_done && start_b_rd)
  );

endmodule

// ==== hw/mem_chan.sv ====
`include "lmem_defs.svh"

module mem_chan import lmem_avmm_pkg::*; (
  input  logic                                Clk_400,
  input  logic                                arst_n,
  input  logic                                start_write,
  input  logic                                start_read,
  input  logic [`LMEM_ADDR_W-1:0]             address,
  input  logic [`LMEM_DATA_W-1:0]             wdata,
  input  logic [`LMEM_BE_W-1:0]               byteenable,
  input  logic [2:0]                          word_sel,
  output logic                                busy,
  output logic                                rd_done,
  output logic [`LMEM_DATA_W-1:0]             rdata,
  output logic                                write_timeout,
  output logic                                read_timeout,
  output logic                                avm_read,
  output logic                                avm_write,
  output logic [`LMEM_ADDR_W-1:0]             avm_address,
  output lmem_line_t                          avm_writedata,
  output logic [`LMEM_LANES*`LMEM_BE_W-1:0]   avm_byteenable,
  input  logic                                avm_waitrequest,
  input  lmem_line_t                          avm_readdata,
  input  logic                                avm_readdatavalid
);

  typedef enum logic [1:0] {
    st_idle,
    st_cmd,
    st_wait
  } state_e;

  localparam logic [`LMEM_TMO_W-1:0] tmo_last = `LMEM_TIMEOUT - 1;

  state_e                  state;
  logic                    is_wr;
  logic [`LMEM_TMO_W-1:0]  cnt;
  logic [`LMEM_DATA_W-1:0] wdata_q;
  logic [`LMEM_BE_W-1:0]   be_q;
  logic [2:0]              sel_q;
  logic                    start;

  assign start = start_write | start_read;
  assign busy  = (state != st_idle) | start; // covers the start cycle

  assign avm_write = (state == st_cmd) & is_wr;
  assign avm_read  = (state == st_cmd) & ~is_wr;

  // same host word in every lane of the line
  always_comb begin
    for (int i = 0; i < `LMEM_LANES; i++) begin
      avm_writedata.lane[i] = wdata_q;
    end
  end
  assign avm_byteenable = {`LMEM_LANES{be_q}};

  always_ff @(posedge Clk_400 or negedge arst_n) begin
    if (!arst_n) begin
      state         <= st_idle;
      is_wr         <= 1'b0;
      cnt           <= '0;
      rd_done       <= 1'b0;
      write_timeout <= 1'b0;
      read_timeout  <= 1'b0;
    end else begin
      rd_done <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            state         <= st_cmd;
            is_wr         <= start_write; // write wins if both set
            cnt           <= '0;
            write_timeout <= 1'b0;
            read_timeout  <= 1'b0;
          end
        end
        st_cmd: begin
          if (!avm_waitrequest) begin
            cnt   <= '0;
            state <= is_wr ? st_idle : st_wait;
          end else if (cnt == tmo_last) begin
            state         <= st_idle; // give up on the command
            write_timeout <= is_wr;
            read_timeout  <= ~is_wr;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_wait: begin
          if (avm_readdatavalid) begin
            rd_done <= 1'b1;
            state   <= st_idle;
          end else if (cnt == tmo_last) begin
            read_timeout <= 1'b1;
            state        <= st_idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // command payload, held until the next start
  always_ff @(posedge Clk_400) begin
    if (state == st_idle && start) begin
      avm_address <= address;
      wdata_q     <= wdata;
      be_q        <= byteenable;
      sel_q       <= word_sel;
    end
    if (state == st_wait && avm_readdatavalid)
      rdata <= avm_readdata.lane[sel_q];
  end

  // single beat, the command drops once accepted
  a_one_beat: assert property (
    @(posedge Clk_400) disable iff (!arst_n)
    (avm_read || avm_write) && !avm_waitrequest |=> !avm_read && !avm_write
  );

  a_addr_hold: assert property (
    @(posedge Clk_400) disable iff (!arst_n)
    (avm_read || avm_write) && avm_waitrequest |=> $stable(avm_address)
  );

endmodule

// ==== hw/lmem_apb_regs.sv ====
`include "lmem_defs.svh"

module lmem_apb_regs import lmem_csr_pkg::*; (
  input  logic                    Clk_400,
  input  logic                    arst_n,
  input  logic [7:0]              paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`LMEM_DATA_W-1:0] pwdata,
  output logic [`LMEM_DATA_W-1:0] prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic                    cmd_valid,
  output lmem_ctrl_t              cmd_ctrl,
  output logic [`LMEM_ADDR_W-1:0] cmd_address,
  output logic [`LMEM_DATA_W-1:0] cmd_wdata,
  input  logic [`LMEM_DATA_W-1:0] host_rdata,
  input  lmem_status_t            host_status
);

  lmem_ctrl_t new_ctrl;
  logic       acc;
  logic       off_ok;
  logic       ctrl_wr;
  logic       a_busy;
  logic       b_busy;
  logic       chan_busy;
  logic       ctrl_ok;

  assign pready   = 1'b1; // no wait states
  assign acc      = psel & penable;
  assign new_ctrl = lmem_ctrl_t'(pwdata);
  assign ctrl_wr  = acc & pwrite & (paddr == `LMEM_REG_CTRL);

  // a command still in flight to local_mem counts as busy too
  assign a_busy = host_status.a_busy | (cmd_valid & (cmd_ctrl.a_write | cmd_ctrl.a_read));
  assign b_busy = host_status.b_busy | (cmd_valid & (cmd_ctrl.b_write | cmd_ctrl.b_read));

  assign chan_busy = ((new_ctrl.a_write | new_ctrl.a_read) & a_busy) |
                     ((new_ctrl.b_write | new_ctrl.b_read) & b_busy);
  assign ctrl_ok   = ctrl_wr & ~chan_busy;

  assign pslverr = acc & (~off_ok | (ctrl_wr & chan_busy));

  always_comb begin
    off_ok = 1'b1;
    case (paddr)
      `LMEM_REG_CTRL:   prdata = cmd_ctrl;
      `LMEM_REG_ADDR:   prdata = {{(`LMEM_DATA_W-`LMEM_ADDR_W){1'b0}}, cmd_address};
      `LMEM_REG_WDATA:  prdata = cmd_wdata;
      `LMEM_REG_RDATA:  prdata = host_rdata;
      `LMEM_REG_STATUS: prdata = host_status;
      default: begin
        prdata = '0;
        off_ok = 1'b0;
      end
    endcase
  end

  always_ff @(posedge Clk_400 or negedge arst_n) begin
    if (!arst_n) begin
      cmd_valid   <= 1'b0;
      cmd_ctrl    <= '0;
      cmd_address <= '0;
      cmd_wdata   <= '0;
    end else begin
      cmd_valid <= ctrl_ok; // one pulse per accepted control write
      if (ctrl_ok)
        cmd_ctrl <= new_ctrl;
      if (acc && pwrite && paddr == `LMEM_REG_ADDR)
        cmd_address <= pwdata[`LMEM_ADDR_W-1:0];
      if (acc && pwrite && paddr == `LMEM_REG_WDATA)
        cmd_wdata <= pwdata;
    end
  end

  // access phase always follows a setup phase
  a_penable_after_psel: assert property (
    @(posedge Clk_400) disable iff (!arst_n)
    $rose(penable) |-> $past(psel)
  );

endmodule

// ==== hw/lmem_avmm_pkg.sv ====
`include "lmem_defs.svh"

package lmem_avmm_pkg;

  // one ddr4 line, seen flat on the avalon bus or as host-word lanes
  typedef union packed {
    logic [`LMEM_LANES*`LMEM_DATA_W-1:0]      flat;
    logic [`LMEM_LANES-1:0][`LMEM_DATA_W-1:0] lane;
  } lmem_line_t;

  // channel that owns the host read data
  typedef enum logic {
    chan_a = 1'b0,
    chan_b = 1'b1
  } lmem_chan_e;

endpackage

// ==== hw/lmem_csr_pkg.sv ====
`include "lmem_defs.svh"

package lmem_csr_pkg;

  // control word, written by the host at LMEM_REG_CTRL
  typedef struct packed {
    logic [44:0]           rsvd_hi;    // 63:19
    logic [2:0]            word_sel;   // lane of the read line
    logic [3:0]            rsvd_lo;    // 15:12
    logic [`LMEM_BE_W-1:0] byteenable; // per host word, replicated
    logic                  b_read;
    logic                  b_write;
    logic                  a_read;
    logic                  a_write;
  } lmem_ctrl_t;

  // status word, read by the host at LMEM_REG_STATUS
  // timeouts are sticky until the next command to that channel
  typedef struct packed {
    logic [56:0] rsvd;
    logic        b_busy;
    logic        b_read_timeout;
    logic        b_write_timeout;
    logic        a_busy;
    logic        a_read_timeout;
    logic        a_write_timeout;
    logic        data_valid;
  } lmem_status_t;

endpackage

// ==== hw/lmem_defs.svh ====
`ifndef LMEM_DEFS_SVH
`define LMEM_DEFS_SVH

// host side widths
`define LMEM_DATA_W 64
`define LMEM_ADDR_W 27
`define LMEM_BE_W 8

// host words per 512-bit memory line
`define LMEM_LANES 8

// cycles to wait on waitrequest or readdatavalid
`define LMEM_TIMEOUT 64
`define LMEM_TMO_W 7

// apb register map
`define LMEM_REG_CTRL 8'h00
`define LMEM_REG_ADDR 8'h08
`define LMEM_REG_WDATA 8'h10
`define LMEM_REG_RDATA 8'h18
`define LMEM_REG_STATUS 8'h20

`endif
